/* Makefile */
VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := tb_cache
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD      := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Cache geometry
`define CACHE_BYTES     256
`define LINE_BYTES      16
`define NUM_WAYS        4
`define NUM_SETS        4

// Address split: tag | index | word offset | byte offset
`define WORD_OFF_BITS   2
`define INDEX_BITS      2
`define TAG_BITS        26
`define WAY_BITS        2

// One line in bits
`define LINE_BITS       128

// Backing line memory, 1 KB
`define MEM_LINES       64
`define MEM_ADDR_BITS   6

// Cycles from a memory request to its done pulse
`define DMEM_DELAY_DEF  4

`endif

/* cache_core.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_core
  import cache_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         mem_rw,
  input  logic         in_valid,
  input  addr_t        addr,
  input  word_t        din,
  output logic         is_hit,
  output word_t        dout,
  output logic         ready,
  input  way_t         victim_way,
  output index_t       lru_index,
  output logic         touch,
  output way_t         touch_way,
  dmem_if.ctrl         mem
);

  // Cache arrays
  logic  valid_q [`NUM_SETS][`NUM_WAYS];
  logic  dirty_q [`NUM_SETS][`NUM_WAYS];
  tag_t  tag_q   [`NUM_SETS][`NUM_WAYS];
  line_t data_q  [`NUM_SETS][`NUM_WAYS];

  cache_state_t state_q;
  cache_state_t state_d;

  // Address fields of the current request
  tag_t    tag;
  index_t  index;
  offset_t offset;

  logic hit_found;
  way_t hit_way;
  logic free_found;
  way_t free_way;
  way_t fill_way;
  logic accept;
  logic miss;

  // Miss context, captured when the miss is taken
  tag_t   miss_tag_q;
  index_t miss_index_q;
  way_t   fill_way_q;

  // Set while a memory access is in flight
  logic issued_q;

  assign tag    = addr[31 -: `TAG_BITS];
  assign index  = addr[`INDEX_BITS + `WORD_OFF_BITS + 1 -: `INDEX_BITS];
  assign offset = addr[`WORD_OFF_BITS + 1 -: `WORD_OFF_BITS];

  always_comb begin
    hit_found = 1'b0;
    hit_way   = '0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (valid_q[index][w] && tag_q[index][w] == tag) begin
        hit_found = 1'b1;
        hit_way   = way_t'(w);
      end
    end
  end

  // Lowest-numbered invalid way wins, so scan from the top down
  always_comb begin
    free_found = 1'b0;
    free_way   = '0;
    for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[index][w]) begin
        free_found = 1'b1;
        free_way   = way_t'(w);
      end
    end
  end

  assign fill_way = free_found ? free_way : victim_way;

  assign ready  = (state_q == ST_IDLE);
  assign accept = ready && in_valid;
  assign is_hit = accept && hit_found;
  assign miss   = accept && !hit_found;
  assign dout   = data_q[index][hit_way][32*offset +: 32];

  // LRU update on every accepted hit
  assign lru_index = index;
  assign touch     = is_hit;
  assign touch_way = hit_way;

  // Memory side, one request pulse per access
  assign mem.req   = (state_q != ST_IDLE) && !issued_q && mem.ready;
  assign mem.write = (state_q == ST_WRITE_BACK);
  assign mem.wdata = data_q[miss_index_q][fill_way_q];

  // Victim goes back to its own line, refill reads the requested line
  always_comb begin
    if (state_q == ST_WRITE_BACK) begin
      mem.line_addr = line_addr_t'({tag_q[miss_index_q][fill_way_q], miss_index_q});
    end else begin
      mem.line_addr = line_addr_t'({miss_tag_q, miss_index_q});
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (miss) begin
          state_d = dirty_q[index][fill_way] ? ST_WRITE_BACK : ST_REFILL;
        end
      end
      ST_WRITE_BACK: begin
        if (mem.done) begin
          state_d = ST_REFILL;
        end
      end
      ST_REFILL: begin
        if (mem.done) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Control state and line status bits
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= ST_IDLE;
      issued_q <= 1'b0;
      for (int s = 0; s < `NUM_SETS; s++) begin
        for (int w = 0; w < `NUM_WAYS; w++) begin
          valid_q[s][w] <= 1'b0;
          dirty_q[s][w] <= 1'b0;
        end
      end
    end else begin
      state_q <= state_d;

      if (mem.done) begin
        issued_q <= 1'b0;
      end else if (mem.req) begin
        issued_q <= 1'b1;
      end

      if (is_hit && mem_rw) begin
        dirty_q[index][hit_way] <= 1'b1;
      end

      // Filled line comes in clean
      if (state_q == ST_REFILL && mem.done) begin
        valid_q[miss_index_q][fill_way_q] <= 1'b1;
        dirty_q[miss_index_q][fill_way_q] <= 1'b0;
      end
    end
  end

  // Tags, line data and miss context
  always_ff @(posedge clk) begin
    if (miss) begin
      miss_tag_q   <= tag;
      miss_index_q <= index;
      fill_way_q   <= fill_way;
    end

    if (is_hit && mem_rw) begin
      data_q[index][hit_way][32*offset +: 32] <= din;
    end

    if (state_q == ST_REFILL && mem.done) begin
      tag_q[miss_index_q][fill_way_q]  <= miss_tag_q;
      data_q[miss_index_q][fill_way_q] <= mem.rdata;
    end
  end

endmodule

/* cache_lru.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_lru
  import cache_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  index_t index,
  input  logic   touch,
  input  way_t   touch_way,
  output way_t   victim_way
);

  // Age 0 is the most recent way, NUM_WAYS-1 the least recent
  way_t age_q [`NUM_SETS][`NUM_WAYS];
  way_t touched_age;

  assign touched_age = age_q[index][touch_way];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        for (int w = 0; w < `NUM_WAYS; w++) begin
          age_q[s][w] <= way_t'(w);
        end
      end
    end else if (touch) begin
      // Ways younger than the touched one grow one step older
      for (int w = 0; w < `NUM_WAYS; w++) begin
        if (age_q[index][w] < touched_age) begin
          age_q[index][w] <= age_q[index][w] + way_t'(1);
        end
      end
      age_q[index][touch_way] <= '0;
    end
  end

  // The oldest way of the set is the victim
  always_comb begin
    victim_way = '0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (age_q[index][w] == way_t'(`NUM_WAYS - 1)) begin
        victim_way = way_t'(w);
      end
    end
  end

endmodule

/* cache_pkg.sv */
`include "cache_consts.svh"

package cache_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Fields of a byte address
  typedef logic [`TAG_BITS-1:0]      tag_t;
  typedef logic [`INDEX_BITS-1:0]    index_t;
  typedef logic [`WORD_OFF_BITS-1:0] offset_t;

  // Way number, also an LRU age
  typedef logic [`WAY_BITS-1:0] way_t;

  typedef logic [`LINE_BITS-1:0]     line_t;
  typedef logic [`MEM_ADDR_BITS-1:0] line_addr_t;

  // Miss handling FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE_BACK,
    ST_REFILL
  } cache_state_t;

endpackage

/* cache_top.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_top
  import cache_pkg::*;
#(
  parameter int DMEM_DELAY = `DMEM_DELAY_DEF
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  mem_rw,
  input  logic  in_valid,
  input  addr_t addr,
  input  word_t din,
  output logic  is_hit,
  output word_t dout,
  output logic  ready,
  output logic  out_valid
);

  dmem_if dmem ();

  index_t lru_index;
  logic   touch;
  way_t   touch_way;
  way_t   victim_way;

  cache_core u_core (
    .clk        (clk),
    .reset      (reset),
    .mem_rw     (mem_rw),
    .in_valid   (in_valid),
    .addr       (addr),
    .din        (din),
    .is_hit     (is_hit),
    .dout       (dout),
    .ready      (ready),
    .victim_way (victim_way),
    .lru_index  (lru_index),
    .touch      (touch),
    .touch_way  (touch_way),
    .mem        (dmem.ctrl)
  );

  cache_lru u_lru (
    .clk        (clk),
    .reset      (reset),
    .index      (lru_index),
    .touch      (touch),
    .touch_way  (touch_way),
    .victim_way (victim_way)
  );

  line_memory #(
    .DMEM_DELAY (DMEM_DELAY)
  ) u_mem (
    .clk   (clk),
    .reset (reset),
    .mem   (dmem.mem)
  );

  // Output data is valid exactly on a hit
  assign out_valid = is_hit;

endmodule

/* dmem_if.sv */
`timescale 1ns/1ns

interface dmem_if import cache_pkg::*; ();

  // Request side, driven by the cache controller
  logic       req;
  logic       write;
  line_addr_t line_addr;
  line_t      wdata;

  // Response side, driven by the line memory
  line_t      rdata;
  logic       done;
  logic       ready;

  modport ctrl (
    output req, write, line_addr, wdata,
    input  rdata, done, ready
  );

  modport mem (
    input  req, write, line_addr, wdata,
    output rdata, done, ready
  );

endinterface

/* flist.f */
+incdir+.
cache_pkg.sv
dmem_if.sv
cache_lru.sv
cache_core.sv
line_memory.sv
cache_top.sv
tb_cache.sv

/* line_memory.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module line_memory
  import cache_pkg::*;
#(
  parameter int DMEM_DELAY = `DMEM_DELAY_DEF
) (
  input  logic clk,
  input  logic reset,
  dmem_if.mem  mem
);

  localparam int CNT_BITS = $clog2(DMEM_DELAY + 1);

  line_t mem_q [`MEM_LINES];

  // Access in progress, held through the done cycle
  logic                busy_q;
  logic                done_q;
  logic [CNT_BITS-1:0] count_q;

  // Latched request
  logic       write_q;
  line_addr_t addr_q;
  line_t      wdata_q;
  line_t      rdata_q;

  logic start;
  logic finish;

  assign start  = mem.req && !busy_q;
  assign finish = busy_q && !done_q && (count_q == CNT_BITS'(DMEM_DELAY - 1));

  assign mem.ready = !busy_q;
  assign mem.done  = done_q;
  assign mem.rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      count_q <= '0;
    end else if (start) begin
      busy_q  <= 1'b1;
      count_q <= '0;
    end else if (done_q) begin
      // Ready comes back the cycle after done
      done_q <= 1'b0;
      busy_q <= 1'b0;
    end else if (finish) begin
      done_q <= 1'b1;
    end else if (busy_q) begin
      count_q <= count_q + CNT_BITS'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      write_q <= mem.write;
      addr_q  <= mem.line_addr;
      wdata_q <= mem.wdata;
    end
  end

  // Line store, cleared by reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MEM_LINES; i++) begin
        mem_q[i] <= '0;
      end
    end else if (finish && write_q) begin
      mem_q[addr_q] <= wdata_q;
    end
  end

  // Read data lines up with the done pulse
  always_ff @(posedge clk) begin
    if (finish && !write_q) begin
      rdata_q <= mem_q[addr_q];
    end
  end

endmodule

/* tb_cache.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module tb_cache import cache_pkg::*; ();

  localparam int PERIOD       = 40;
  localparam int HALF         = PERIOD / 2;
  localparam int SAMPLE       = PERIOD / 4;
  localparam int TIMEOUT      = 200;
  localparam int RESET_CYCLES = 8;

  logic  clk;
  logic  reset;
  logic  mem_rw;
  logic  in_valid;
  addr_t addr;
  word_t din;
  logic  is_hit;
  word_t dout;
  logic  ready;
  logic  out_valid;

  // Reference image of the 1 KB backing memory with one entry per word
  word_t ref_mem [256];

  // Resident tags per set in LRU order with the most recent in entry 0
  logic [`TAG_BITS-1:0] res_tag [`NUM_SETS][`NUM_WAYS];
  int                   res_count [`NUM_SETS];

  int checks;
  int errors;
  int timeouts;
  bit timed_out;
  int seed;

  cache_top uut (
    .clk       (clk),
    .reset     (reset),
    .mem_rw    (mem_rw),
    .in_valid  (in_valid),
    .addr      (addr),
    .din       (din),
    .is_hit    (is_hit),
    .dout      (dout),
    .ready     (ready),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(HALF) clk = ~clk;
  end

  function automatic word_t random_word();
    return $random(seed);
  endfunction

  function automatic bit is_resident(input addr_t a);
    bit found;
    found = 1'b0;
    for (int i = 0; i < res_count[a[5:4]]; i++) begin
      if (res_tag[a[5:4]][i] == a[31:6]) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // Move the tag to the front
  // A new tag in a full set drops the oldest
  task automatic mark_used(input addr_t a);
    int idx;
    int pos;
    idx = int'(a[5:4]);
    pos = res_count[idx];
    for (int i = 0; i < res_count[idx]; i++) begin
      if (res_tag[idx][i] == a[31:6]) begin
        pos = i;
      end
    end
    if (pos == `NUM_WAYS) begin
      pos = `NUM_WAYS - 1;
    end else if (pos == res_count[idx]) begin
      res_count[idx]++;
    end
    for (int i = pos; i > 0; i--) begin
      res_tag[idx][i] = res_tag[idx][i-1];
    end
    res_tag[idx][0] = a[31:6];
  endtask

  task automatic check_word(input string name, input word_t got, input word_t expected);
    checks++;
    assert (got === expected) else begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    checks++;
    assert (got === expected) else begin
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, expected);
      errors++;
    end
  endtask

  // One request held until the cache reports a hit with ready high
  task automatic access(input logic wr, input addr_t a, input word_t wdata);
    bit    expect_hit;
    word_t expect_data;
    int    cycles;
    if (!timed_out) begin
      expect_hit  = is_resident(a);
      expect_data = ref_mem[a[9:2]];
      @(negedge clk);
      mem_rw   = wr;
      in_valid = 1'b1;
      addr     = a;
      din      = wdata;
      #(SAMPLE);
      check_flag("ready", ready, 1'b1);
      check_flag("is_hit", is_hit, expect_hit);
      check_flag("out_valid", out_valid, expect_hit);
      cycles = 0;
      while (!(is_hit && ready) && cycles < TIMEOUT) begin
        @(negedge clk);
        #(SAMPLE);
        cycles++;
        if (cycles == 1 && !expect_hit) begin
          check_flag("ready", ready, 1'b0);
        end
      end
      if (is_hit && ready) begin
        check_flag("out_valid", out_valid, 1'b1);
        if (wr) begin
          ref_mem[a[9:2]] = wdata;
        end else begin
          check_word("dout", dout, expect_data);
        end
        mark_used(a);
      end else begin
        $display("Timeout: access to address %h did not complete in %0d cycles", a, TIMEOUT);
        timeouts++;
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic write_line_words();
    for (int w = 0; w < 4; w++) begin
      access(1'b1, addr_t'(32'h040 + w * 4), random_word());
    end
    access(1'b1, 32'h048, random_word());
    for (int w = 0; w < 4; w++) begin
      access(1'b0, addr_t'(32'h040 + w * 4), '0);
    end
  endtask

  // Five tags in set 3 in an order that leaves tag 1 as the oldest
  task automatic evict_lru_tag();
    access(1'b1, 32'h030, random_word());
    access(1'b0, 32'h070, '0);
    access(1'b1, 32'h0B0, random_word());
    access(1'b0, 32'h0F0, '0);
    access(1'b0, 32'h030, '0);
    access(1'b0, 32'h0B0, '0);
    access(1'b0, 32'h130, '0);
    access(1'b0, 32'h030, '0);
    access(1'b0, 32'h0B0, '0);
    access(1'b0, 32'h0F0, '0);
    access(1'b0, 32'h070, '0);
  endtask

  task automatic evict_dirty_lines();
    word_t r;
    for (int i = 0; i < 48; i++) begin
      r = random_word();
      access(1'b1, {23'd0, r[8:2], 2'b00}, random_word());
    end
    for (int w = 0; w < 128; w++) begin
      access(1'b0, addr_t'(w * 4), '0);
    end
  endtask

  // Lines above 0x200 were never written, so reading them pushes out every dirty line
  task automatic flush_cache();
    for (int s = 0; s < `NUM_SETS; s++) begin
      for (int t = 0; t < `NUM_WAYS; t++) begin
        access(1'b0, addr_t'(32'h200 + t * 64 + s * 16), '0);
      end
    end
  endtask

  task automatic read_address_aliases();
    addr_t alias_off [4];
    word_t r;
    alias_off[0] = 32'h0000_0000;
    alias_off[1] = 32'h0000_0400;
    alias_off[2] = 32'h0000_1C00;
    alias_off[3] = 32'h8000_0000;
    for (int i = 0; i < 12; i++) begin
      r = random_word();
      for (int k = 0; k < 4; k++) begin
        access(1'b0, {23'd0, r[8:2], 2'b00} | alias_off[k], '0);
      end
    end
  endtask

  initial begin
    reset     = 1'b1;
    mem_rw    = 1'b0;
    in_valid  = 1'b0;
    addr      = '0;
    din       = '0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    timed_out = 1'b0;
    seed      = 97;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = '0;
    end
    for (int s = 0; s < `NUM_SETS; s++) begin
      res_count[s] = 0;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #(SAMPLE);
    check_flag("ready", ready, 1'b1);
    check_flag("is_hit", is_hit, 1'b0);

    // Read miss, then the same word again as a hit
    access(1'b0, 32'h000, '0);
    access(1'b0, 32'h000, '0);
    access(1'b1, 32'h104, random_word());
    access(1'b0, 32'h104, '0);

    write_line_words();
    evict_lru_tag();
    evict_dirty_lines();
    flush_cache();
    read_address_aliases();

    @(negedge clk);
    in_valid = 1'b0;
    $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
